// File: boardCtrlTop.f
logic/boardCtrlPkg.sv
logic/regBusDecoder.sv
logic/gpioBlock.sv
logic/ledBlinker.sv
logic/boardCtrlTop.sv
verif/boardCtrlTb.sv

// File: logic/boardCtrlPkg.sv
/*
 * Board control shared definitions
 * Bus widths, block address map, register offsets and the
 * structs that carry the APB request and GPIO alternate sources
 */
package boardCtrlPkg;

  // --------------------------------------------------------------------------
  // Widths with a meaning of their own
  // --------------------------------------------------------------------------
  typedef logic [15:0] busAddrT;
  typedef logic [31:0] busDataT;
  // Address bits 9:8
  typedef logic [1:0]  blockIdxT;
  // Address bits 7:0
  typedef logic [7:0]  csrOffsT;
  typedef logic [2:0]  gpioPadT;
  typedef logic [27:0] cntT;

  // APB request minus PSEL for broadcast to every block
  typedef struct packed {
    busAddrT paddr;
    logic    pwrite;
    busDataT pwdata;
    logic    penable;
  } apbReqT;

  // Sources for the GPIO alternate functions
  typedef struct packed {
    logic pllLocked;
    logic blink;
  } altSrcT;

  // --------------------------------------------------------------------------
  // Block address map
  // --------------------------------------------------------------------------
  localparam int lpBlockNum   = 4;
  localparam int lpGpioBlock  = 0;
  localparam int lpBlinkBlock = 1;

  // GPIO registers
  localparam csrOffsT lpGpioOutOffs = 8'h00;
  localparam csrOffsT lpGpioDirOffs = 8'h04;
  localparam csrOffsT lpGpioAltOffs = 8'h08;
  localparam csrOffsT lpGpioInOffs  = 8'h0C;

  // Blinker registers
  localparam csrOffsT lpBlinkHalfOffs  = 8'h00;
  localparam csrOffsT lpBlinkCtrlOffs  = 8'h04;
  localparam csrOffsT lpBlinkStateOffs = 8'h08;

endpackage

// File: logic/boardCtrlTop.sv
/*
 * Board control top level
 * APB slave port decoded onto the GPIO block and the LED blinker
 */
module boardCtrlTop
  import boardCtrlPkg::*;
#(
  parameter cntT pHalfPeriodDefault = 24999999
)
(
  input  logic    iSCLK,
  input  logic    qnARST,
  input  logic    psel,
  input  apbReqT  apbReq,
  output busDataT prdata,
  output logic    pslverr,
  input  logic    pllLocked,
  input  gpioPadT gpioIn,
  output gpioPadT gpioOut,
  output gpioPadT gpioOe
);

  logic    wBlkSel [lpBlockNum];
  busDataT wBlkRd [lpBlockNum];
  logic    wBlink;
  altSrcT  wAltSrc;

  // Slots 2 and 3 have no block behind them
  assign wBlkRd[2] = '0;
  assign wBlkRd[3] = '0;

  assign wAltSrc.pllLocked = pllLocked;
  assign wAltSrc.blink     = wBlink;

  regBusDecoder i_regBusDecoder (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .psel(psel),       .apbReq(apbReq),
    .blkSel(wBlkSel),  .blkRd(wBlkRd),
    .prdata(prdata),   .pslverr(pslverr)
  );

  gpioBlock i_gpioBlock (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .sel(wBlkSel[lpGpioBlock]),
    .apbReq(apbReq),
    .rdData(wBlkRd[lpGpioBlock]),
    .altSrc(wAltSrc),
    .gpioIn(gpioIn),   .gpioOut(gpioOut),
    .gpioOe(gpioOe)
  );

  ledBlinker #(
    .pHalfPeriodDefault(pHalfPeriodDefault)
  ) i_ledBlinker (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .sel(wBlkSel[lpBlinkBlock]),
    .apbReq(apbReq),
    .rdData(wBlkRd[lpBlinkBlock]),
    .blink(wBlink)
  );

endmodule

// File: logic/gpioBlock.sv
/*
 * GPIO block
 * Output data, direction and alternate-enable registers for three pins,
 * a synchronised input register and the per-pin alternate output mux
 * Pin 0 alternate source is PLL lock, pin 2 is the heartbeat LED
 */
module gpioBlock
  import boardCtrlPkg::*;
(
  input  logic    iSCLK,
  input  logic    qnARST,
  input  logic    sel,
  input  apbReqT  apbReq,
  output busDataT rdData,
  input  altSrcT  altSrc,
  input  gpioPadT gpioIn,
  output gpioPadT gpioOut,
  output gpioPadT gpioOe
);

  // Pin 1 has no alternate source
  localparam gpioPadT lpAltMask = 3'b101;

  csrOffsT wOffs;
  logic    wWr;
  gpioPadT wAltVal;
  gpioPadT rOut;
  gpioPadT rDir;
  gpioPadT rAlt;
  gpioPadT rSync;
  gpioPadT rIn;

  assign wOffs = apbReq.paddr[7:0];
  // Write lands on the edge that ends the enable phase
  assign wWr   = sel && apbReq.penable && apbReq.pwrite;

  // --------------------------------------------------------------------------
  // Control registers
  // --------------------------------------------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      rOut <= '0;
      rDir <= '0;
      rAlt <= '0;
    end
    else if (wWr)
    begin
      case (wOffs)
        lpGpioOutOffs: rOut <= apbReq.pwdata[2:0];
        lpGpioDirOffs: rDir <= apbReq.pwdata[2:0];
        lpGpioAltOffs: rAlt <= apbReq.pwdata[2:0] & lpAltMask;
        default: ;
      endcase
    end
  end

  // Two-flop synchroniser whose second stage is the input register
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      rSync <= '0;
      rIn   <= '0;
    end
    else
    begin
      rSync <= gpioIn;
      rIn   <= rSync;
    end
  end

  // --------------------------------------------------------------------------
  // Read mux
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (wOffs)
      lpGpioOutOffs: rdData = busDataT'(rOut);
      lpGpioDirOffs: rdData = busDataT'(rDir);
      lpGpioAltOffs: rdData = busDataT'(rAlt);
      lpGpioInOffs:  rdData = busDataT'(rIn);
      default:       rdData = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Pin drive
  // --------------------------------------------------------------------------
  assign wAltVal = {altSrc.blink, 1'b0, altSrc.pllLocked};
  assign gpioOut = (rAlt & wAltVal) | (~rAlt & rOut);
  assign gpioOe  = rDir;

  // Input offset is read only and aliases nothing
  assert property (@(posedge iSCLK) disable iff (!qnARST)
    (wWr && wOffs == lpGpioInOffs) |=> $stable({rOut, rDir, rAlt}))
  else
    $error("write to GPIO input offset changed a register");

endmodule

// File: logic/ledBlinker.sv
/*
 * Heartbeat LED blinker
 * Counts up to a programmable half period and inverts the blink
 * level each time it wraps, with enable and state registers
 */
module ledBlinker
  import boardCtrlPkg::*;
#(
  parameter cntT pHalfPeriodDefault = 24999999
)
(
  input  logic    iSCLK,
  input  logic    qnARST,
  input  logic    sel,
  input  apbReqT  apbReq,
  output busDataT rdData,
  output logic    blink
);

  csrOffsT wOffs;
  logic    wWr;
  logic    wCfgWr;
  cntT     rHalf;
  cntT     rCnt;
  logic    rEn;
  logic    rBlink;

  assign wOffs  = apbReq.paddr[7:0];
  assign wWr    = sel && apbReq.penable && apbReq.pwrite;
  // Any change of setup restarts the count
  assign wCfgWr = wWr && (wOffs == lpBlinkHalfOffs || wOffs == lpBlinkCtrlOffs);

  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      rHalf <= pHalfPeriodDefault;
      rEn   <= 1'b1;
    end
    else if (wWr)
    begin
      if (wOffs == lpBlinkHalfOffs)
        rHalf <= apbReq.pwdata[27:0];
      if (wOffs == lpBlinkCtrlOffs)
        rEn <= apbReq.pwdata[0];
    end
  end

  // --------------------------------------------------------------------------
  // Counter and toggle
  // --------------------------------------------------------------------------
  always_ff @(posedge iSCLK or negedge qnARST)
  begin
    if (!qnARST)
    begin
      rCnt   <= '0;
      rBlink <= 1'b0;
    end
    else if (!rEn)
    begin
      rCnt   <= '0;
      rBlink <= 1'b0;
    end
    else if (wCfgWr)
      rCnt <= '0;
    else if (rCnt == rHalf)
    begin
      rCnt   <= '0;
      rBlink <= ~rBlink;
    end
    else
      rCnt <= rCnt + 1'b1;
  end

  always_comb
  begin
    case (wOffs)
      lpBlinkHalfOffs:  rdData = busDataT'(rHalf);
      lpBlinkCtrlOffs:  rdData = busDataT'(rEn);
      lpBlinkStateOffs: rdData = busDataT'(rBlink);
      default:          rdData = '0;
    endcase
  end

  assign blink = rBlink;

  // A shorter half period written mid count must not strand the counter
  assert property (@(posedge iSCLK) disable iff (!qnARST)
    rEn |-> (rCnt <= rHalf))
  else
    $error("blinker counter above half period");

endmodule

// File: logic/regBusDecoder.sv
/*
 * Register bus decoder
 * Splits the APB address into a block index and an offset,
 * raises one select per block slot, muxes the read data back
 * and flags accesses that hit no mapped block
 */
module regBusDecoder
  import boardCtrlPkg::*;
(
  input  logic    iSCLK,
  input  logic    qnARST,
  input  logic    psel,
  input  apbReqT  apbReq,
  output logic    blkSel [lpBlockNum],
  input  busDataT blkRd [lpBlockNum],
  output busDataT prdata,
  output logic    pslverr
);

  blockIdxT wIdx;
  logic     wInRange;
  logic     wMapped;

  // --------------------------------------------------------------------------
  // Address split
  // --------------------------------------------------------------------------
  assign wIdx     = apbReq.paddr[9:8];
  // Bits above the block field must be clear
  assign wInRange = (apbReq.paddr[15:10] == '0);
  assign wMapped  = wInRange &&
                    ((wIdx == blockIdxT'(lpGpioBlock)) ||
                     (wIdx == blockIdxT'(lpBlinkBlock)));

  // One select per slot
  always_comb
  begin
    for (int i = 0; i < lpBlockNum; i++)
    begin
      blkSel[i] = psel && wInRange && (wIdx == blockIdxT'(i));
    end
  end

  // --------------------------------------------------------------------------
  // Read data and error
  // --------------------------------------------------------------------------
  // Unmapped slots read zero
  assign prdata  = (psel && wMapped) ? blkRd[wIdx] : '0;
  assign pslverr = psel && apbReq.penable && !wMapped;

  // Protocol checks on the incoming bus
  assert property (@(posedge iSCLK) disable iff (!qnARST)
    apbReq.penable |-> psel)
  else
    $error("penable high without psel");

  // Setup is always followed by enable with the same address
  assert property (@(posedge iSCLK) disable iff (!qnARST)
    (psel && !apbReq.penable) |=> (psel && apbReq.penable && $stable(apbReq.paddr)))
  else
    $error("paddr not held from setup to enable");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module boardCtrlTb -f boardCtrlTop.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

// File: verif/boardCtrlTb.sv
/*
 * Board control testbench
 * Drives the APB port of the board control top level, keeps a shadow
 * copy of the registers, compares reads and pins against it and times
 * the heartbeat on GPIO pin 2
 */
module boardCtrlTb;
  import boardCtrlPkg::*;

  // Watchdog budget in clock cycles
  localparam int lpAccessCnt   = 80;
  localparam int lpBlinkCycles = 80;
  localparam int lpLimitCycles = (lpAccessCnt * 2 + lpBlinkCycles) * 4;
  // Unmapped slots and addresses with upper bits set
  localparam busAddrT lpErrAddr [4] = '{16'h0200, 16'h0304, 16'h0404, 16'hFD00};

  logic    iSCLK;
  logic    qnARST;
  logic    psel;
  apbReqT  apbReq;
  busDataT prdata;
  logic    pslverr;
  logic    pllLocked;
  gpioPadT gpioIn;
  gpioPadT gpioOut;
  gpioPadT gpioOe;

  integer  seed;
  int      passCnt;
  int      failCnt;
  int      testErr;
  logic    pinChk;
  busDataT rdVal;
  logic    errVal;
  gpioPadT shOut;
  gpioPadT shDir;
  gpioPadT shAlt;
  gpioPadT shIn;
  cntT     shHalf;
  logic    shEn;

  boardCtrlTop #(.pHalfPeriodDefault(9)) i_boardCtrlTop (
    .iSCLK(iSCLK),         .qnARST(qnARST),
    .psel(psel),           .apbReq(apbReq),
    .prdata(prdata),       .pslverr(pslverr),
    .pllLocked(pllLocked), .gpioIn(gpioIn),
    .gpioOut(gpioOut),     .gpioOe(gpioOe)
  );

  always #10 iSCLK = ~iSCLK;

  // --------------------------------------------------------------------------
  // Reference model returning {pslverr, prdata}
  // --------------------------------------------------------------------------
  function automatic logic [32:0] expRead(input busAddrT addr);
    if (addr[15:10] != 6'h0 || addr[9:8] > 2'd1)
      return {1'b1, 32'h0};
    if (addr[9:8] == blockIdxT'(lpGpioBlock))
    begin
      case (addr[7:0])
        lpGpioOutOffs: return {30'h0, shOut};
        lpGpioDirOffs: return {30'h0, shDir};
        lpGpioAltOffs: return {30'h0, shAlt};
        lpGpioInOffs:  return {30'h0, shIn};
        default:       return 33'h0;
      endcase
    end
    case (addr[7:0])
      lpBlinkHalfOffs: return {5'h0, shHalf};
      lpBlinkCtrlOffs: return {32'h0, shEn};
      // State is only read with the blinker off
      default:         return 33'h0;
    endcase
  endfunction

  function automatic gpioPadT expPins();
    expPins[0] = shAlt[0] ? pllLocked : shOut[0];
    expPins[1] = shOut[1];
    expPins[2] = shAlt[2] ? 1'b0 : shOut[2];
  endfunction

  task automatic mismatch(input string name, input busDataT exp, input busDataT act);
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    testErr++;
  endtask

  // One zero-wait APB transfer sampled mid enable phase
  task automatic apbAccess(input busAddrT addr, input logic wr, input busDataT data);
    @(posedge iSCLK);
    #2;
    psel           = 1'b1;
    apbReq.paddr   = addr;
    apbReq.pwrite  = wr;
    apbReq.pwdata  = data;
    apbReq.penable = 1'b0;
    @(posedge iSCLK);
    #2;
    apbReq.penable = 1'b1;
    @(negedge iSCLK);
    rdVal  = prdata;
    errVal = pslverr;
    @(posedge iSCLK);
    #2;
    psel           = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic writeReg(input busAddrT addr, input busDataT data);
    logic [32:0] exp;
    exp = expRead(addr);
    apbAccess(addr, 1'b1, data);
    if (errVal !== exp[32])
      mismatch($sformatf("pslverr[%h]", addr), busDataT'(exp[32]), busDataT'(errVal));
    if (!exp[32] && addr[9:8] == 2'd0)
    begin
      case (addr[7:0])
        lpGpioOutOffs: shOut = data[2:0];
        lpGpioDirOffs: shDir = data[2:0];
        // Pin 1 has no alternate function
        lpGpioAltOffs: shAlt = data[2:0] & 3'b101;
        default: ;
      endcase
    end
    else if (!exp[32] && addr[7:0] == lpBlinkHalfOffs)
      shHalf = data[27:0];
    else if (!exp[32] && addr[7:0] == lpBlinkCtrlOffs)
      shEn = data[0];
  endtask

  task automatic readCheck(input busAddrT addr);
    logic [32:0] exp;
    exp = expRead(addr);
    apbAccess(addr, 1'b0, 32'h0);
    if (rdVal !== exp[31:0])
      mismatch($sformatf("prdata[%h]", addr), exp[31:0], rdVal);
    if (errVal !== exp[32])
      mismatch($sformatf("pslverr[%h]", addr), busDataT'(exp[32]), busDataT'(errVal));
  endtask

  task automatic endTest(input string name);
    if (testErr == 0)
    begin
      passCnt++;
      $display("%s: pass", name);
    end
    else
    begin
      failCnt++;
      $display("%s: fail with %0d errors", name, testErr);
    end
    testErr = 0;
  endtask

  // Pins and the bus error flag on every falling edge
  always @(negedge iSCLK)
  begin
    gpioPadT mask;
    // Running heartbeat is timed by the alternate function test
    mask = (shAlt[2] && shEn) ? 3'b011 : 3'b111;
    if (qnARST && pinChk)
    begin
      if (gpioOe !== shDir)
        mismatch("gpioOe", busDataT'(shDir), busDataT'(gpioOe));
      if ((gpioOut & mask) !== (expPins() & mask))
        mismatch("gpioOut", busDataT'(expPins() & mask), busDataT'(gpioOut & mask));
    end
    // Error only ever flagged in an enable phase
    if (qnARST && !(psel && apbReq.penable) && pslverr !== 1'b0)
      mismatch("pslverr", 32'h0, busDataT'(pslverr));
  end

  initial
  begin
    #(lpLimitCycles * 20);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int unsigned r;
    int          n;
    logic        prev;
    busAddrT     a;
    seed = 32'h76e7;
    {iSCLK, qnARST, psel, pllLocked, pinChk} = '0;
    apbReq = '0;
    gpioIn = '0;
    {passCnt, failCnt, testErr} = '0;
    {shOut, shDir, shAlt, shIn} = '0;
    shHalf = 28'd9;
    shEn   = 1'b1;
    repeat (5) @(posedge iSCLK);
    #2;
    qnARST = 1'b1;
    pinChk = 1'b1;

    @(negedge iSCLK);
    if (pslverr !== 1'b0)
      mismatch("pslverr", 32'h0, busDataT'(pslverr));
    for (int i = 0; i < 4; i++)
      readCheck(busAddrT'(i * 4));
    readCheck(16'h0100);
    readCheck(16'h0104);
    writeReg(16'h0104, 32'h0);
    readCheck(16'h0108);
    writeReg(16'h0104, 32'h1);
    endTest("reset state");

    for (int i = 0; i < 20; i++)
    begin
      r = $random(seed);
      @(posedge iSCLK);
      #2;
      pllLocked = r[8];
      a = {8'h00, csrOffsT'((r % 3) * 4)};
      writeReg(a, $random(seed));
      readCheck(a);
    end
    endTest("gpio register write and read");

    for (int i = 0; i < 4; i++)
    begin
      @(posedge iSCLK);
      #2;
      shIn   = gpioPadT'($random(seed));
      gpioIn = shIn;
      repeat (3) @(posedge iSCLK);
      readCheck(16'h000C);
    end
    writeReg(16'h000C, $random(seed));
    for (int i = 0; i < 4; i++)
      readCheck(busAddrT'(i * 4));
    endTest("gpio input path");

    writeReg(16'h0004, 32'h7);
    writeReg(16'h0000, 32'h0);
    writeReg(16'h0008, 32'h7);
    for (int i = 0; i < 6; i++)
    begin
      @(posedge iSCLK);
      #2;
      pllLocked = ~pllLocked;
      @(posedge iSCLK);
    end
    writeReg(16'h0100, 32'd4);
    // Find one toggle and time the next four
    @(negedge iSCLK);
    prev = gpioOut[2];
    n = 0;
    while (gpioOut[2] === prev && n < 20)
    begin
      @(negedge iSCLK);
      n++;
    end
    if (n >= 20)
    begin
      $display("At %0t GPIO pin 2 never toggled with the blinker running", $time);
      testErr++;
    end
    for (int k = 0; k < 4; k++)
    begin
      prev = gpioOut[2];
      n = 1;
      @(negedge iSCLK);
      while (gpioOut[2] === prev && n < 20)
      begin
        @(negedge iSCLK);
        n++;
      end
      if (n != 5)
        mismatch("gpioOut[2] toggle period", 32'd5, busDataT'(n));
    end
    // Blink clears one cycle after the enable drops
    pinChk = 1'b0;
    writeReg(16'h0104, 32'h0);
    repeat (2) @(posedge iSCLK);
    pinChk = 1'b1;
    repeat (10) @(posedge iSCLK);
    readCheck(16'h0108);
    endTest("alternate functions");

    for (int i = 0; i < 4; i++)
    begin
      writeReg(lpErrAddr[i], $random(seed));
      readCheck(lpErrAddr[i]);
    end
    writeReg(16'h0010, $random(seed));
    readCheck(16'h0010);
    for (int i = 0; i < 3; i++)
      readCheck(busAddrT'(i * 4));
    readCheck(16'h0100);
    readCheck(16'h0104);
    endTest("error responses");

    $display("Tests passed %0d, failed %0d", passCnt, failCnt);
    if (failCnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
